// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_dc_control
FILELIST  = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF '*** PASSED ***' $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
source/control_types_pkg.sv
source/monitor_pkg.sv
source/reset_sequencer.sv
source/status_led_driver.sv
source/event_monitor.sv
source/dc_control_top.sv
verification/dc_control_checker.sv
verification/tb_dc_control.sv

// ==== source/control_types_pkg.sv ====
package control_types_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // reset targets

    // one request pulses one line
    typedef enum logic {
        RESET_CONSOLE,
        RESET_DRIVE
    } reset_target_e;

    ////////////////////////////////////////////////////////////////////////////
    // status led

    typedef enum logic [1:0] {
        LED_STATUS,
        LED_MIRROR_DRIVE,
        LED_MIRROR_CONSOLE,
        LED_OFF
    } led_mode_e;

    // synchronized link flags, same field order as the raw inputs
    typedef struct packed {
        logic pll54_locked;
        logic pll_hdmi_locked;
        logic resync;
        logic force_generate;
    } link_status_t;

endpackage

// ==== source/dc_control_top.sv ====
`timescale 1ns/1ps

module dc_control_top import control_types_pkg::*, monitor_pkg::*; #(
    parameter int hold_cycles   = 32_000_000,
    parameter int slow_glow_bit = 26,
    parameter int fast_glow_bit = 22,
    parameter int blink_bit     = 24
) (
    input  logic          control_clock,
    input  logic          reset_dc,
    input  logic          reset_req,
    input  reset_target_e reset_target,
    input  event_raw_t    raw_events,
    input  logic          adv_ready,
    input  led_mode_e     led_mode,
    input  logic          rd_req,
    input  counter_sel_e  rd_sel,
    output logic          reset_ack,
    output logic          console_nreset,
    output logic          drive_nreset,
    output logic          status_led,
    output logic          rd_ack,
    output event_count_t  rd_data
);

    link_status_t link_status;

    reset_sequencer #(
        .hold_cycles(hold_cycles)
    ) u_reset_sequencer (
        .control_clock  (control_clock),
        .reset_dc       (reset_dc),
        .reset_req      (reset_req),
        .reset_target   (reset_target),
        .reset_ack      (reset_ack),
        .console_nreset (console_nreset),
        .drive_nreset   (drive_nreset)
    );

    event_monitor u_event_monitor (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .raw_events    (raw_events),
        .rd_req        (rd_req),
        .rd_sel        (rd_sel),
        .link_status   (link_status),
        .rd_ack        (rd_ack),
        .rd_data       (rd_data)
    );

    // led sees the same reset lines that leave the board
    status_led_driver #(
        .slow_glow_bit(slow_glow_bit),
        .fast_glow_bit(fast_glow_bit),
        .blink_bit    (blink_bit)
    ) u_status_led_driver (
        .control_clock  (control_clock),
        .reset_dc       (reset_dc),
        .link_status    (link_status),
        .adv_ready      (adv_ready),
        .led_mode       (led_mode),
        .console_nreset (console_nreset),
        .drive_nreset   (drive_nreset),
        .status_led     (status_led)
    );

endmodule

// ==== source/event_monitor.sv ====
`timescale 1ns/1ps

module event_monitor import control_types_pkg::*, monitor_pkg::*; (
    input  logic         control_clock,
    input  logic         reset_dc,
    input  event_raw_t   raw_events,
    input  logic         rd_req,
    input  counter_sel_e rd_sel,
    output link_status_t link_status,
    output logic         rd_ack,
    output event_count_t rd_data
);

    event_raw_t              sync_meta;
    event_raw_t              sync_q;
    event_raw_t              sync_prev;
    logic [num_counters-1:0] edge_seen;
    logic [num_counters-1:0] event_pulse;
    event_count_t            event_count [num_counters];
    event_count_t            sel_count;

    ////////////////////////////////////////////////////////////////////////////
    // synchronizers and edge detect

    assign link_status.pll54_locked    = sync_q.pll54_locked;
    assign link_status.pll_hdmi_locked = sync_q.pll_hdmi_locked;
    assign link_status.resync          = sync_q.resync;
    assign link_status.force_generate  = sync_q.force_generate;

    // lock loss is a falling edge, resync a rising one
    always_comb begin
        edge_seen[CNT_PLL54_LOSS]    = sync_prev.pll54_locked & ~sync_q.pll54_locked;
        edge_seen[CNT_PLL_HDMI_LOSS] = sync_prev.pll_hdmi_locked & ~sync_q.pll_hdmi_locked;
        edge_seen[CNT_RESYNC]        = ~sync_prev.resync & sync_q.resync;
    end

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            sync_meta   <= '0;
            sync_q      <= '0;
            sync_prev   <= '0;
            event_pulse <= '0;
            for (int i = 0; i < num_counters; i++) begin
                event_count[i] <= '0;
            end
        end else begin
            sync_meta   <= raw_events;
            sync_q      <= sync_meta;
            sync_prev   <= sync_q;
            event_pulse <= edge_seen;
            // counters wrap
            for (int i = 0; i < num_counters; i++) begin
                if (event_pulse[i]) begin
                    event_count[i] <= event_count[i] + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // readout handshake

    always_comb begin
        case (rd_sel)
            CNT_PLL54_LOSS:    sel_count = event_count[CNT_PLL54_LOSS];
            CNT_PLL_HDMI_LOSS: sel_count = event_count[CNT_PLL_HDMI_LOSS];
            CNT_RESYNC:        sel_count = event_count[CNT_RESYNC];
            default:           sel_count = '0;
        endcase
    end

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            rd_ack <= 1'b0;
        end else if (rd_req && !rd_ack) begin
            rd_ack <= 1'b1;
        end else if (!rd_req && rd_ack) begin
            rd_ack <= 1'b0;
        end
    end

    // snapshot taken on the ack edge, held while ack is up
    always_ff @(posedge control_clock) begin
        if (rd_req && !rd_ack) begin
            rd_data <= sel_count;
        end
    end

    ack_needs_req: assert property (@(posedge control_clock) disable iff (reset_dc)
        $rose(rd_ack) |-> $past(rd_req));

endmodule

// ==== source/monitor_pkg.sv ====
package monitor_pkg;

    // one counter per selector value
    localparam int num_counters = 3;
    localparam int count_w      = 32;

    typedef enum logic [1:0] {
        CNT_PLL54_LOSS,
        CNT_PLL_HDMI_LOSS,
        CNT_RESYNC
    } counter_sel_e;

    typedef logic [count_w-1:0] event_count_t;

    // async pins straight off the board
    typedef struct packed {
        logic pll54_locked;
        logic pll_hdmi_locked;
        logic resync;
        logic force_generate;
    } event_raw_t;

endpackage

// ==== source/reset_sequencer.sv ====
`timescale 1ns/1ps

module reset_sequencer import control_types_pkg::*; #(
    parameter int hold_cycles = 32_000_000
) (
    input  logic          control_clock,
    input  logic          reset_dc,
    input  logic          reset_req,
    input  reset_target_e reset_target,
    output logic          reset_ack,
    output logic          console_nreset,
    output logic          drive_nreset
);

    localparam int hold_w = $clog2(hold_cycles + 1);

    typedef enum logic [1:0] {
        IDLE,
        HOLD,
        ACK
    } seq_state_e;

    seq_state_e        state;
    logic [hold_w-1:0] hold_count;
    logic              ack_pending;
    logic              hold_done;

    // last cycle of the hold
    assign hold_done = (hold_count == hold_w'(hold_cycles - 1));

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            // power-on hold of both lines, no ack at the end
            state          <= HOLD;
            hold_count     <= '0;
            ack_pending    <= 1'b0;
            reset_ack      <= 1'b0;
            console_nreset <= 1'b0;
            drive_nreset   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (reset_req) begin
                        state       <= HOLD;
                        hold_count  <= '0;
                        ack_pending <= 1'b1;
                        if (reset_target == RESET_CONSOLE) begin
                            console_nreset <= 1'b0;
                        end else begin
                            drive_nreset <= 1'b0;
                        end
                    end
                end
                HOLD: begin
                    if (hold_done) begin
                        console_nreset <= 1'b1;
                        drive_nreset   <= 1'b1;
                        reset_ack      <= ack_pending;
                        state          <= ack_pending ? ACK : IDLE;
                    end else begin
                        hold_count <= hold_count + 1'b1;
                    end
                end
                ACK: begin
                    // host may sit on req, ack just stays up
                    if (!reset_req) begin
                        reset_ack   <= 1'b0;
                        ack_pending <= 1'b0;
                        state       <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // handshake checks

    ack_after_release: assert property (@(posedge control_clock) disable iff (reset_dc)
        reset_ack |-> (console_nreset && drive_nreset));

    target_stable: assert property (@(posedge control_clock) disable iff (reset_dc)
        (reset_req && !reset_ack) ##1 (reset_req && !reset_ack) |-> $stable(reset_target));

endmodule

// ==== source/status_led_driver.sv ====
`timescale 1ns/1ps

module status_led_driver import control_types_pkg::*; #(
    parameter int slow_glow_bit = 26,
    parameter int fast_glow_bit = 22,
    parameter int blink_bit     = 24
) (
    input  logic         control_clock,
    input  logic         reset_dc,
    input  link_status_t link_status,
    input  logic         adv_ready,
    input  led_mode_e    led_mode,
    input  logic         console_nreset,
    input  logic         drive_nreset,
    output logic         status_led
);

    localparam int upper_bit = (slow_glow_bit > blink_bit) ? slow_glow_bit : blink_bit;
    localparam int pattern_w = ((upper_bit > fast_glow_bit) ? upper_bit : fast_glow_bit) + 1;

    logic [pattern_w-1:0] pattern_cnt;
    logic                 dim_lit;
    logic                 slow_lit;
    logic                 fast_lit;
    logic                 blink_lit;
    logic                 status_lit;

    // triangle brightness from the 8 bits under glow_bit, pwm on the low byte
    function automatic logic glow_lit(input logic [pattern_w-1:0] cnt, input int glow_bit);
        logic [7:0] level;
        level = cnt[glow_bit-1 -: 8];
        if (cnt[glow_bit]) begin
            level = ~level;
        end
        return cnt[7:0] < level;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // patterns

    assign dim_lit   = (pattern_cnt[2:0] == 3'd0);
    assign slow_lit  = glow_lit(pattern_cnt, slow_glow_bit);
    assign fast_lit  = glow_lit(pattern_cnt, fast_glow_bit);
    assign blink_lit = fast_lit & pattern_cnt[blink_bit];

    // first match wins
    always_comb begin
        if (!link_status.pll_hdmi_locked) begin
            status_lit = dim_lit;
        end else if (link_status.resync) begin
            status_lit = fast_lit;
        end else if (link_status.force_generate) begin
            status_lit = blink_lit;
        end else if (adv_ready) begin
            status_lit = 1'b1;
        end else begin
            status_lit = slow_lit;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output stage, active low

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            pattern_cnt <= '0;
            status_led  <= 1'b1;
        end else begin
            pattern_cnt <= pattern_cnt + 1'b1;
            case (led_mode)
                LED_STATUS:         status_led <= ~status_lit;
                LED_MIRROR_DRIVE:   status_led <= drive_nreset;
                LED_MIRROR_CONSOLE: status_led <= console_nreset;
                default:            status_led <= 1'b1;
            endcase
        end
    end

endmodule

// ==== verification/dc_control_checker.sv ====
`timescale 1ns/1ps

module dc_control_checker import monitor_pkg::*; #(
    parameter int hold_cycles = 40
) (
    input  logic            control_clock,
    input  logic            reset_dc,
    input  logic            reset_req,
    input  logic            reset_ack,
    input  logic            console_nreset,
    input  logic            drive_nreset,
    input  logic            status_led,
    input  logic            rd_req,
    input  logic            rd_ack,
    input  event_count_t    rd_data,
    input  logic            window_open,
    input  logic            check_strobe,
    input  logic [1:0]      check_kind,
    input  logic [8*20-1:0] check_name,
    input  logic [31:0]     check_expected,
    output int              check_count,
    output int              error_count
);

    int           checks = 0;
    int           errors = 0;
    int           req_wait = 0;
    logic         ack_q = 1'b0;
    logic         req_q = 1'b0;
    logic         con_q = 1'b0;
    logic         drv_q = 1'b0;
    logic         rd_req_q = 1'b0;
    logic         rd_ack_q = 1'b0;
    logic         window_q = 1'b0;
    event_count_t data_q = '0;
    logic [15:0]  led_lit = '0;
    logic [15:0]  led_dark = '0;
    logic [7:0]   con_low = '0;
    logic [7:0]   drv_low = '0;
    logic [31:0]  actual;

    assign check_count = checks;
    assign error_count = errors;

    task automatic flag_error(input string what);
        errors++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // sampled on the falling edge away from the DUT's updates

    always @(negedge control_clock) begin
        if (reset_dc) begin
            req_wait = 0;
        end else begin
            if (reset_req && !reset_ack) begin
                req_wait++;
            end else begin
                req_wait = 0;
            end
            if (req_wait == hold_cycles + 8) begin
                flag_error("reset request was never acknowledged");
            end
            if (reset_ack && !ack_q &&
                !((console_nreset && !con_q) || (drive_nreset && !drv_q))) begin
                flag_error("reset_ack rose without a reset line being released");
            end
            if (ack_q && req_q && !reset_ack) begin
                flag_error("reset_ack fell while reset_req was still high");
            end
            if (ack_q && !req_q && reset_ack) begin
                flag_error("reset_ack stayed high after reset_req was dropped");
            end
            if (rd_req_q && !rd_ack_q && !rd_ack) begin
                flag_error("rd_ack did not answer rd_req");
            end
            if (rd_ack_q && rd_req_q && !rd_ack) begin
                flag_error("rd_ack fell while rd_req was still high");
            end
            if (!rd_req_q && rd_ack_q && rd_ack) begin
                flag_error("rd_ack stayed high after rd_req was dropped");
            end
            if (rd_ack && !rd_ack_q && !rd_req_q) begin
                flag_error("rd_ack rose without rd_req");
            end
            if (rd_ack && rd_ack_q && rd_data !== data_q) begin
                flag_error("rd_data changed while rd_ack was high");
            end
        end
        // level counts over the measuring window
        if (window_open) begin
            if (!window_q) begin
                led_lit  = '0;
                led_dark = '0;
                con_low  = '0;
                drv_low  = '0;
            end
            if (!status_led) begin
                led_lit++;
            end else begin
                led_dark++;
            end
            if (!console_nreset) begin
                con_low++;
            end
            if (!drive_nreset) begin
                drv_low++;
            end
        end
        if (check_strobe) begin
            case (check_kind)
                2'd0:    actual = {led_lit, con_low, drv_low};
                2'd1:    actual = {30'd0, led_lit != 16'd0, led_dark != 16'd0};
                default: actual = rd_data;
            endcase
            checks++;
            if (actual !== check_expected) begin
                errors++;
                $display("FAIL %0s expected %h actual %h", check_name, check_expected, actual);
            end
        end
        ack_q    = reset_ack;
        req_q    = reset_req;
        con_q    = console_nreset;
        drv_q    = drive_nreset;
        rd_req_q = rd_req;
        rd_ack_q = rd_ack;
        window_q = window_open;
        data_q   = rd_data;
    end

endmodule

// ==== verification/dc_control_golden.txt ====
# name op a b c expected, all operands and expected values in hex
# window expected is {led lit count[15:0], console low[7:0], drive low[7:0]}
power_on        power  2  0  0  00282828
con_mirror      pulse  0  2  0  00282800
drv_mirror      pulse  1  1  0  00280028
con_led_off     pulse  0  3  0  00002800
drv_second      pulse  1  2  0  00000028
led_off         led    c  0  3  00000000
led_ready       led    c  1  0  00400000
pll54_burst     count  0  5  0  00000005
hdmi_burst      count  1  3  0  00000003
resync_burst    count  2  7  0  00000007
pll54_reread    read   0  0  0  00000005
hdmi_reread     read   1  0  0  00000003
led_dim         led    8  0  0  00080000
led_fast_glow   glow   e  0  0  00000003

// ==== verification/tb_dc_control.sv ====
`timescale 1ns/1ps

module tb_dc_control import control_types_pkg::*, monitor_pkg::*; ();

    localparam int hold_cycles   = 40;
    localparam int slow_glow_bit = 12;
    localparam int fast_glow_bit = 9;
    localparam int blink_bit     = 10;
    localparam int max_records   = 32;
    localparam int led_window    = 64;

    localparam logic [1:0] kind_window = 2'd0;
    localparam logic [1:0] kind_levels = 2'd1;
    localparam logic [1:0] kind_data   = 2'd2;

    logic          control_clock = 1'b0;
    logic          reset_dc;
    logic          reset_req;
    reset_target_e reset_target;
    event_raw_t    raw_events;
    logic          adv_ready;
    led_mode_e     led_mode;
    logic          rd_req;
    counter_sel_e  rd_sel;
    logic          reset_ack;
    logic          console_nreset;
    logic          drive_nreset;
    logic          status_led;
    logic          rd_ack;
    event_count_t  rd_data;

    logic              window_open;
    logic              check_strobe;
    logic [1:0]        check_kind;
    logic [8*20-1:0]   check_name;
    logic [31:0]       check_expected;
    int                check_count;
    int                error_count;

    logic [8*20-1:0] rec_name [max_records];
    string           rec_op   [max_records];
    logic [31:0]     rec_a    [max_records];
    logic [31:0]     rec_b    [max_records];
    logic [31:0]     rec_c    [max_records];
    logic [31:0]     rec_exp  [max_records];
    int              num_records = 0;
    int              setup_errors = 0;
    bit              loaded = 1'b0;
    logic [31:0]     lfsr_state;

    always #5 control_clock = ~control_clock;

    dc_control_top #(
        .hold_cycles  (hold_cycles),
        .slow_glow_bit(slow_glow_bit),
        .fast_glow_bit(fast_glow_bit),
        .blink_bit    (blink_bit)
    ) u_dut (
        .control_clock  (control_clock),
        .reset_dc       (reset_dc),
        .reset_req      (reset_req),
        .reset_target   (reset_target),
        .raw_events     (raw_events),
        .adv_ready      (adv_ready),
        .led_mode       (led_mode),
        .rd_req         (rd_req),
        .rd_sel         (rd_sel),
        .reset_ack      (reset_ack),
        .console_nreset (console_nreset),
        .drive_nreset   (drive_nreset),
        .status_led     (status_led),
        .rd_ack         (rd_ack),
        .rd_data        (rd_data)
    );

    dc_control_checker #(
        .hold_cycles(hold_cycles)
    ) u_checker (
        .control_clock  (control_clock),
        .reset_dc       (reset_dc),
        .reset_req      (reset_req),
        .reset_ack      (reset_ack),
        .console_nreset (console_nreset),
        .drive_nreset   (drive_nreset),
        .status_led     (status_led),
        .rd_req         (rd_req),
        .rd_ack         (rd_ack),
        .rd_data        (rd_data),
        .window_open    (window_open),
        .check_strobe   (check_strobe),
        .check_kind     (check_kind),
        .check_name     (check_name),
        .check_expected (check_expected),
        .check_count    (check_count),
        .error_count    (error_count)
    );

    ////////////////////////////////////////////////////////////////////////////
    // golden records and random hold lengths

    task automatic load_records();
        int              fd;
        int              n;
        string           line;
        string           op;
        logic [8*20-1:0] name;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     c;
        logic [31:0]     e;
        fd = $fopen("verification/dc_control_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden record file");
            setup_errors++;
            return;
        end
        while (!$feof(fd) && num_records < max_records) begin
            line = "";
            void'($fgets(line, fd));
            if (line.getc(0) == "#") continue;
            n = $sscanf(line, "%s %s %h %h %h %h", name, op, a, b, c, e);
            if (n == 6) begin
                rec_name[num_records] = name;
                rec_op[num_records]   = op;
                rec_a[num_records]    = a;
                rec_b[num_records]    = b;
                rec_c[num_records]    = c;
                rec_exp[num_records]  = e;
                num_records++;
            end
        end
        $fclose(fd);
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic take_bits(input int count, output int value);
        value = 0;
        for (int k = 0; k < count; k++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // handshake helpers

    // which selects reset_ack (0) or rd_ack (1)
    task automatic wait_for(input int which, input logic level, input int limit);
        int   n;
        logic seen;
        n    = 0;
        seen = ~level;
        while (seen !== level && n < limit) begin
            @(negedge control_clock);
            seen = (which == 0) ? reset_ack : rd_ack;
            n++;
        end
    endtask

    task automatic strobe_check(input logic [1:0] kind, input int i);
        @(posedge control_clock);
        check_kind     <= kind;
        check_name     <= rec_name[i];
        check_expected <= rec_exp[i];
        check_strobe   <= 1'b1;
        @(posedge control_clock);
        check_strobe <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // record operations

    task automatic power_cycle(input int i);
        @(posedge control_clock);
        led_mode <= led_mode_e'(rec_a[i][1:0]);
        reset_dc <= 1'b1;
        repeat (5) @(posedge control_clock);
        reset_dc    <= 1'b0;
        window_open <= 1'b1;
        // window covers the whole power-on hold plus a margin
        repeat (hold_cycles + 4) @(posedge control_clock);
        window_open <= 1'b0;
        strobe_check(kind_window, i);
    endtask

    task automatic request_pulse(input int i);
        @(posedge control_clock);
        reset_target <= reset_target_e'(rec_a[i][0]);
        led_mode     <= led_mode_e'(rec_b[i][1:0]);
        repeat (4) @(posedge control_clock);
        window_open <= 1'b1;
        reset_req   <= 1'b1;
        wait_for(0, 1'b1, hold_cycles + 12);
        @(posedge control_clock);
        reset_req <= 1'b0;
        wait_for(0, 1'b0, 4);
        @(posedge control_clock);
        window_open <= 1'b0;
        strobe_check(kind_window, i);
    endtask

    task automatic measure_led(input int i, input logic [1:0] kind, input int window);
        @(posedge control_clock);
        raw_events <= event_raw_t'(rec_a[i][3:0]);
        adv_ready  <= rec_b[i][0];
        led_mode   <= led_mode_e'(rec_c[i][1:0]);
        // synchronizer plus output register
        repeat (8) @(posedge control_clock);
        window_open <= 1'b1;
        repeat (window) @(posedge control_clock);
        window_open <= 1'b0;
        strobe_check(kind, i);
    endtask

    // locked bits start high and fall while resync starts low and rises
    task automatic event_burst(input int i);
        logic [1:0] bit_idx;
        int         events;
        int         extra;
        events  = int'(rec_b[i]);
        bit_idx = (rec_a[i] == 0) ? 2'd3 : ((rec_a[i] == 1) ? 2'd2 : 2'd1);
        for (int k = 0; k < 2 * events; k++) begin
            take_bits(2, extra);
            @(posedge control_clock);
            raw_events[bit_idx] <= ~raw_events[bit_idx];
            repeat (5 + extra) @(posedge control_clock);
        end
        repeat (8) @(posedge control_clock);
    endtask

    task automatic read_counter(input int i);
        @(posedge control_clock);
        rd_sel <= counter_sel_e'(rec_a[i][1:0]);
        rd_req <= 1'b1;
        wait_for(1, 1'b1, 4);
        strobe_check(kind_data, i);
        rd_req <= 1'b0;
        wait_for(1, 1'b0, 4);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        reset_dc       = 1'b1;
        reset_req      = 1'b0;
        reset_target   = RESET_CONSOLE;
        raw_events     = event_raw_t'(4'hc);
        adv_ready      = 1'b0;
        led_mode       = LED_OFF;
        rd_req         = 1'b0;
        rd_sel         = CNT_PLL54_LOSS;
        window_open    = 1'b0;
        check_strobe   = 1'b0;
        check_kind     = kind_window;
        check_name     = '0;
        check_expected = '0;
        lfsr_state     = 32'h7d0de26b;
        load_records();
        loaded = 1'b1;
        for (int i = 0; i < num_records; i++) begin
            if (rec_op[i] == "power") begin
                power_cycle(i);
            end else if (rec_op[i] == "pulse") begin
                request_pulse(i);
            end else if (rec_op[i] == "led") begin
                measure_led(i, kind_window, led_window);
            end else if (rec_op[i] == "glow") begin
                measure_led(i, kind_levels, 2 ** (fast_glow_bit + 1));
            end else if (rec_op[i] == "count") begin
                event_burst(i);
                read_counter(i);
            end else if (rec_op[i] == "read") begin
                read_counter(i);
            end else begin
                $display("record %0d has an unknown operation %s", i, rec_op[i]);
                setup_errors++;
            end
        end
        repeat (4) @(posedge control_clock);
        $display("checks %0d, errors %0d", check_count, error_count + setup_errors);
        if (error_count == 0 && setup_errors == 0 && check_count > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (loaded);
        repeat (num_records * (hold_cycles + 2 ** (slow_glow_bit + 1)) + 2000) begin
            @(posedge control_clock);
        end
        $display("watchdog expired before the record sequence finished");
        $display("checks %0d, errors %0d", check_count, error_count + setup_errors + 1);
        $display("*** FAILED ***");
        $finish;
    end

endmodule
